/* dice_config.svh */
`ifndef DICE_CONFIG_SVH
`define DICE_CONFIG_SVH

// faces on the die.
// the display decode only knows values up to 20.
`define DICE_SIDES 20

// ticks in one roll.
`define ROLL_TICKS 12

// clock cycles per tick.
`define TICK_CYCLES 4

// lfsr reset value, must be nonzero.
`define LFSR_SEED 16'hACE1

`endif

/* dice_pkg.sv */
`default_nettype none

package dice_pkg;

    // face value, 0 means nothing rolled yet.
    typedef logic [4:0] die_value_t;

    typedef struct packed {
        logic seg_invert;
        logic graphical;
    } disp_ctrl_t;

    typedef struct packed {
        die_value_t value;
        logic       valid;
    } roll_result_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ROLLING = 2'd1,
        SHOW    = 2'd2
    } roll_state_t;

endpackage

`default_nettype wire

/* dice_rng.sv */
`default_nettype none

`include "dice_config.svh"

module dice_rng (
    input  wire                         clk,
    input  wire                         rst_n,
    output dice_pkg::die_value_t        sample
);

    import dice_pkg::*;

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right.
    localparam logic [15:0] TAPS  = 16'hB400;
    localparam die_value_t  SIDES = die_value_t'(`DICE_SIDES);

    logic [15:0] lfsr;
    die_value_t  field;
    die_value_t  folded;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? TAPS : 16'h0000);
        end
    end

    // fold 0..31 onto 1..SIDES.
    assign field  = lfsr[4:0];
    assign folded = (field >= SIDES) ? field - SIDES : field;
    assign sample = folded + 5'd1;

    // an all-zero state would lock up.
    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        lfsr != 16'h0000
    );

endmodule

`default_nettype wire

/* dice_top.sv */
`default_nettype none

module dice_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        roll_button,
    input  wire  dice_pkg::disp_ctrl_t ctrl,
    output logic [6:0]                 segments,
    output logic [1:0]                 digit_sel,
    output dice_pkg::roll_result_t     result
);

    import dice_pkg::*;

    wire             timer_start;
    wire             tick;
    wire             done;
    wire die_value_t sample;

    roll_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .roll_button (roll_button),
        .tick        (tick),
        .done        (done),
        .sample      (sample),
        .timer_start (timer_start),
        .result      (result)
    );

    roll_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .tick  (tick),
        .done  (done)
    );

    dice_rng u_rng (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample)
    );

    // the display follows the tumbling value during a roll.
    display u_display (
        .clk       (clk),
        .rst_n     (rst_n),
        .value     (result.value),
        .ctrl      (ctrl),
        .segments  (segments),
        .digit_sel (digit_sel)
    );

endmodule

`default_nettype wire

/* display.sv */
`default_nettype none

module display (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  dice_pkg::die_value_t value,
    input  wire  dice_pkg::disp_ctrl_t ctrl,
    output logic [6:0]                 segments,
    output logic [1:0]                 digit_sel
);

    import dice_pkg::*;

    logic       tens_phase;
    logic [6:0] seg_raw;
    logic [1:0] sel_raw;

    // segments are g down to a.
    function automatic logic [6:0] ones_pattern(input die_value_t v);
        case (v)
            5'd1,  5'd11: ones_pattern = 7'b0000110;
            5'd2,  5'd12: ones_pattern = 7'b1011011;
            5'd3,  5'd13: ones_pattern = 7'b1001111;
            5'd4,  5'd14: ones_pattern = 7'b1100110;
            5'd5,  5'd15: ones_pattern = 7'b1101101;
            5'd6,  5'd16: ones_pattern = 7'b1111101;
            5'd7,  5'd17: ones_pattern = 7'b0000111;
            5'd8,  5'd18: ones_pattern = 7'b1111111;
            5'd9,  5'd19: ones_pattern = 7'b1101111;
            5'd10, 5'd20: ones_pattern = 7'b0111111;
            default:      ones_pattern = 7'b0000000;
        endcase
    endfunction

    function automatic logic [6:0] tens_pattern(input die_value_t v);
        if (v == 5'd20) begin
            tens_pattern = 7'b1011011;
        end else if (v >= 5'd10 && v <= 5'd19) begin
            tens_pattern = 7'b0000110;
        end else begin
            tens_pattern = 7'b0000000;
        end
    endfunction

    // each segment lights once value reaches its threshold.
    function automatic logic [6:0] bar_pattern(input die_value_t v, input logic tens);
        if (tens) begin
            bar_pattern = {v >= 5'd7,  v >= 5'd3,  v >= 5'd9, v >= 5'd13,
                           v >= 5'd10, v >= 5'd4,  v >= 5'd1};
        end else begin
            bar_pattern = {v >= 5'd8,  v >= 5'd5,  v >= 5'd11, v >= 5'd14,
                           v >= 5'd12, v >= 5'd6,  v >= 5'd2};
        end
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tens_phase <= 1'b0;
            seg_raw    <= 7'b0000000;
            sel_raw    <= 2'b00;
        end else begin
            tens_phase <= ~tens_phase;
            if (tens_phase) begin
                sel_raw <= 2'b10;
                seg_raw <= ctrl.graphical ? bar_pattern(value, 1'b1) : tens_pattern(value);
            end else begin
                sel_raw <= 2'b01;
                seg_raw <= ctrl.graphical ? bar_pattern(value, 1'b0) : ones_pattern(value);
            end
        end
    end

    // common-anode parts want everything inverted.
    assign segments  = seg_raw ^ {7{ctrl.seg_invert}};
    assign digit_sel = sel_raw ^ {2{ctrl.seg_invert}};

    // one digit driven per cycle, the two taking turns once out of reset.
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) && $past(rst_n, 2) |-> $onehot(sel_raw) && sel_raw == ~$past(sel_raw)
    );

endmodule

`default_nettype wire

/* roll_fsm.sv */
`default_nettype none

`include "dice_config.svh"

module roll_fsm (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        roll_button,
    input  wire                        tick,
    input  wire                        done,
    input  wire  dice_pkg::die_value_t sample,
    output logic                       timer_start,
    output dice_pkg::roll_result_t     result
);

    import dice_pkg::*;

    localparam die_value_t SIDES = die_value_t'(`DICE_SIDES);

    logic [1:0]  btn_sync;
    logic        btn_prev;
    logic        press;
    roll_state_t state;

    // rising edge of the synchronized button.
    assign press = btn_sync[1] & ~btn_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_sync <= 2'b00;
            btn_prev <= 1'b0;
        end else begin
            btn_sync <= {btn_sync[0], roll_button};
            btn_prev <= btn_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            timer_start <= 1'b0;
            result      <= '0;
        end else begin
            timer_start <= 1'b0;
            case (state)
                IDLE, SHOW: begin
                    if (press) begin
                        state        <= ROLLING;
                        timer_start  <= 1'b1;
                        result.valid <= 1'b0;
                    end
                end
                ROLLING: begin
                    // presses are ignored here.
                    // the shown value tumbles with every tick.
                    if (tick) begin
                        result.value <= sample;
                    end
                    if (done) begin
                        state        <= SHOW;
                        result.valid <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a finished roll always carries a legal face.
    a_valid_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        result.valid |-> (result.value >= 5'd1) && (result.value <= SIDES)
    );

endmodule

`default_nettype wire

/* roll_timer.sv */
`default_nettype none

`include "dice_config.svh"

module roll_timer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,
    output logic tick,
    output logic done
);

    localparam int PRE_W  = (`TICK_CYCLES > 1) ? $clog2(`TICK_CYCLES) : 1;
    localparam int TICK_W = (`ROLL_TICKS > 1) ? $clog2(`ROLL_TICKS) : 1;
    localparam logic [PRE_W-1:0]  PRE_LAST  = PRE_W'(`TICK_CYCLES - 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`ROLL_TICKS - 1);

    logic              running;
    logic [PRE_W-1:0]  pre_cnt;
    logic [TICK_W-1:0] tick_cnt;

    assign tick = running && (pre_cnt == PRE_LAST);
    assign done = tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            pre_cnt  <= '0;
            tick_cnt <= '0;
        end else if (start) begin
            // restart the whole roll.
            running  <= 1'b1;
            pre_cnt  <= '0;
            tick_cnt <= '0;
        end else if (running) begin
            if (tick) begin
                pre_cnt <= '0;
                if (done) begin
                    running  <= 1'b0;
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    // ticks come a full prescale period after the start or the previous tick.
    a_tick_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        tick |-> $past(start, `TICK_CYCLES) || $past(tick, `TICK_CYCLES)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dice roller testbench with Verilator.
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_dice
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dice 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* tb.f */
+incdir+.
dice_pkg.sv
roll_timer.sv
dice_rng.sv
roll_fsm.sv
display.sv
dice_top.sv
tb_dice.sv

/* tb_dice.sv */
`default_nettype none

`include "dice_config.svh"

module tb_dice;

    timeunit 1ns;
    timeprecision 1ps;

    import dice_pkg::*;

    // press to valid, counted in falling edges.
    localparam int ROLL_CYC = 3 + `ROLL_TICKS * `TICK_CYCLES;
    localparam int WIN_LO = ROLL_CYC - 1;
    localparam int WIN_HI = ROLL_CYC + 2;
    localparam int ROLL_COUNT = 13;
    localparam int MAX_GAP = 20;
    localparam int WATCHDOG_CYC = 16 + ROLL_COUNT * (WIN_HI + MAX_GAP + 20) + 200;

    logic         clk;
    logic         rst_n;
    logic         roll_button;
    disp_ctrl_t   ctrl;
    logic [6:0]   segments;
    logic [1:0]   digit_sel;
    roll_result_t result;

    integer seed;
    int     errors;
    int     passes;
    int     test_errors;

    // clock edges since reset was released.
    int     run_edges;

    // bar thresholds, element 0 is segment g.
    int tens_thr [7];
    int ones_thr [7];

    dice_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .roll_button (roll_button),
        .ctrl        (ctrl),
        .segments    (segments),
        .digit_sel   (digit_sel),
        .result      (result)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n) begin
            run_edges <= 0;
        end else begin
            run_edges <= run_edges + 1;
        end
    end

    function automatic logic [6:0] digit_segs(input int d);
        case (d)
            0:       digit_segs = 7'b0111111;
            1:       digit_segs = 7'b0000110;
            2:       digit_segs = 7'b1011011;
            3:       digit_segs = 7'b1001111;
            4:       digit_segs = 7'b1100110;
            5:       digit_segs = 7'b1101101;
            6:       digit_segs = 7'b1111101;
            7:       digit_segs = 7'b0000111;
            8:       digit_segs = 7'b1111111;
            9:       digit_segs = 7'b1101111;
            default: digit_segs = 7'b0000000;
        endcase
    endfunction

    function automatic logic [6:0] ones_ref(input int v);
        ones_ref = (v >= 1 && v <= 20) ? digit_segs(v % 10) : 7'b0000000;
    endfunction

    function automatic logic [6:0] tens_ref(input int v);
        if (v == 20) begin
            tens_ref = digit_segs(2);
        end else if (v >= 10 && v <= 19) begin
            tens_ref = digit_segs(1);
        end else begin
            tens_ref = 7'b0000000;
        end
    endfunction

    function automatic logic [6:0] bar_ref(input int v, input logic tens);
        for (int k = 0; k < 7; k++) begin
            bar_ref[6-k] = v >= (tens ? tens_thr[k] : ones_thr[k]);
        end
    endfunction

    task automatic mismatch(input string name, input int expected, input int actual);
        $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic failure(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // one press, optionally a second one later, until valid comes back.
    task automatic do_roll(input int hold, input int second_at, output int cycles,
                           output logic dropped);
        cycles = 0;
        dropped = 1'b0;
        roll_button = 1'b1;
        while (cycles < WIN_HI + 8) begin
            @(negedge clk);
            cycles++;
            if (cycles == hold) begin
                roll_button = 1'b0;
            end
            if (second_at > 0 && cycles == second_at) begin
                roll_button = 1'b1;
            end
            if (second_at > 0 && cycles == second_at + 3) begin
                roll_button = 1'b0;
            end
            if (!result.valid) begin
                dropped = 1'b1;
            end else if (dropped) begin
                break;
            end
        end
        roll_button = 1'b0;
    endtask

    task automatic check_roll(input int cycles, input logic dropped);
        if (!dropped) begin
            failure("result.valid did not drop at the start of the roll");
        end else begin
            passes++;
        end
        if (cycles < WIN_LO || cycles > WIN_HI) begin
            failure($sformatf("roll took %0d cycles, allowed %0d to %0d",
                              cycles, WIN_LO, WIN_HI));
        end else begin
            passes++;
        end
        if (result.value < 1 || result.value > 20) begin
            failure($sformatf("result.value %0d is outside 1 to 20", result.value));
        end else begin
            passes++;
        end
    endtask

    task automatic check_display(input int n, input logic graphical, input logic invert);
        logic [1:0] exp_sel;
        logic [6:0] exp_seg;
        logic [6:0] seg_mask;
        logic [1:0] sel_mask;
        seg_mask = {7{invert}};
        sel_mask = {2{invert}};
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            // the ones digit comes first after reset.
            exp_sel = run_edges[0] ? 2'b01 : 2'b10;
            if (exp_sel == 2'b01) begin
                exp_seg = graphical ? bar_ref(result.value, 1'b0) : ones_ref(result.value);
            end else begin
                exp_seg = graphical ? bar_ref(result.value, 1'b1) : tens_ref(result.value);
            end
            if (digit_sel !== (exp_sel ^ sel_mask)) begin
                mismatch("digit_sel", exp_sel ^ sel_mask, digit_sel);
            end else begin
                passes++;
            end
            if (segments !== (exp_seg ^ seg_mask)) begin
                mismatch("segments", exp_seg ^ seg_mask, segments);
            end else begin
                passes++;
            end
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (result !== '0) begin
                mismatch("result", 0, result);
            end else begin
                passes++;
            end
            if (segments !== {7{ctrl.seg_invert}}) begin
                mismatch("segments", {7{ctrl.seg_invert}}, segments);
            end else begin
                passes++;
            end
            if (digit_sel !== {2{ctrl.seg_invert}}) begin
                mismatch("digit_sel", {2{ctrl.seg_invert}}, digit_sel);
            end else begin
                passes++;
            end
            if (i == 7) begin
                ctrl.seg_invert = 1'b1;
            end
        end
        ctrl = '0;
        rst_n = 1'b1;
        @(negedge clk);
        if (result !== '0) begin
            mismatch("result", 0, result);
        end else begin
            passes++;
        end
        finish_test("reset state");
    endtask

    task automatic test_roll_completes();
        int         cycles;
        logic       dropped;
        die_value_t held;
        do_roll(2, 0, cycles, dropped);
        check_roll(cycles, dropped);
        held = result.value;
        repeat (10) begin
            @(negedge clk);
            if (result.value !== held) begin
                mismatch("result.value", held, result.value);
            end else begin
                passes++;
            end
        end
        finish_test("roll completes");
    endtask

    task automatic test_numeric();
        check_display(8, 1'b0, 1'b0);
        finish_test("numeric display");
    endtask

    task automatic test_modes();
        ctrl.graphical = 1'b1;
        repeat (2) @(negedge clk);
        check_display(8, 1'b1, 1'b0);
        ctrl.seg_invert = 1'b1;
        @(negedge clk);
        check_display(8, 1'b1, 1'b1);
        ctrl.graphical = 1'b0;
        repeat (2) @(negedge clk);
        check_display(8, 1'b0, 1'b1);
        ctrl = '0;
        repeat (2) @(negedge clk);
        finish_test("graphical and inverted modes");
    endtask

    // both rolls start from SHOW, each with an extra press while rolling.
    task automatic test_press_handling();
        int   cycles;
        logic dropped;
        do_roll(2, 20, cycles, dropped);
        check_roll(cycles, dropped);
        repeat (3) @(negedge clk);
        do_roll(1, ROLL_CYC - 7, cycles, dropped);
        check_roll(cycles, dropped);
        finish_test("press handling");
    endtask

    task automatic test_spread();
        int          gap;
        int          hold;
        int          cycles;
        logic        dropped;
        logic [31:0] seen;
        seen = '0;
        for (int i = 0; i < 10; i++) begin
            gap = 1 + $unsigned($random(seed)) % MAX_GAP;
            hold = 1 + $unsigned($random(seed)) % 8;
            repeat (gap) @(negedge clk);
            do_roll(hold, 0, cycles, dropped);
            check_roll(cycles, dropped);
            seen[result.value] = 1'b1;
        end
        if ($countones(seen) < 2) begin
            failure("ten rolls produced fewer than two distinct values");
        end else begin
            passes++;
        end
        finish_test("spread");
    endtask

    initial begin
        #(WATCHDOG_CYC * 100);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed = 97432;
        errors = 0;
        passes = 0;
        test_errors = 0;
        tens_thr = '{7, 3, 9, 13, 10, 4, 1};
        ones_thr = '{8, 5, 11, 14, 12, 6, 2};
        rst_n = 1'b0;
        roll_button = 1'b0;
        ctrl = '0;
        test_reset();
        test_roll_completes();
        test_numeric();
        test_modes();
        test_press_handling();
        test_spread();
        $display("checks passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
